//--- common/arcade_glue_pkg.sv
/*
 * Arcade glue shared definitions
 * Vector types, core-mode numbers, advance hold length and SDRAM layout
 */
package arcade_glue_pkg;

	typedef logic [6:0]  core_mod_t;   // Game selected by the loader
	typedef logic [31:0] status_t;     // Menu option word
	typedef logic [9:0]  player_t;     // {F, E, D, C, B, A, up, down, left, right}
	typedef logic [8:0]  ctrl_t;       // {tilt, coin4..coin1, start4..start1}
	typedef logic [7:0]  joy_t;        // Active low JA / JB
	typedef logic [3:0]  btn_t;        // {start A, start B, coin, reset}
	typedef logic [7:0]  sw_t;
	typedef logic [24:0] dl_addr_t;    // Download byte address
	typedef logic [22:0] sdram_addr_t; // SDRAM word address
	typedef logic [23:1] cpu_addr_t;   // CPU word address
	typedef logic [7:0]  snd_t;
	typedef logic [15:0] speech_t;
	typedef logic [16:0] mix_t;

	// Core-mode numbers
	localparam core_mod_t CORE_ROBOTRON = 7'd0;
	localparam core_mod_t CORE_JOUST    = 7'd1;
	localparam core_mod_t CORE_SPLAT    = 7'd2;
	localparam core_mod_t CORE_BUBBLES  = 7'd3;
	localparam core_mod_t CORE_STARGATE = 7'd4;
	localparam core_mod_t CORE_ALIENAR  = 7'd5;
	localparam core_mod_t CORE_SINISTAR = 7'd6;
	localparam core_mod_t CORE_PLAYBALL = 7'd7;
	localparam core_mod_t CORE_LOTTO    = 7'd8;

	// Length of the service switch pulse in clocks
	localparam logic [19:0] ADV_HOLD = 20'hFFFFF;

	/*
	 * Download image layout:
	 * 00000-0BFFF main CPU, 0C000-0CFFF sound CPU,
	 * 0D000-0D3FF CMOS RAM, 0E000-11FFF speech
	 */
	localparam dl_addr_t    CMOS_PAGE  = 25'h000D000;
	localparam sdram_addr_t CMOS_BASE  = 23'h01CC00; // CMOS lives behind the game RAM
	localparam int          CMOS_OFS_W = 10;         // 1k window

	// {left/right, landscape/portrait}
	localparam logic [1:0] ORIENT_LANDSCAPE = 2'b10;
	localparam logic [1:0] ORIENT_PORTRAIT  = 2'b01;

endpackage

//--- input_map/game_input_map.sv
/*
 * Game input mapping
 * Builds the cabinet BTN, JA and JB wiring for the selected game,
 * plus the Sinistar direction latches and service switches
 */
`timescale 1ns/100ps

module game_input_map (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  arcade_glue_pkg::core_mod_t core_mod,
	input  arcade_glue_pkg::player_t   player1,
	input  arcade_glue_pkg::player_t   player2,
	input  arcade_glue_pkg::ctrl_t     controls,
	input  logic                       advance,
	input  logic                       autoup,
	input  logic                       game_reset,
	output arcade_glue_pkg::btn_t      btn,
	output arcade_glue_pkg::joy_t      ja,
	output arcade_glue_pkg::joy_t      jb,
	output arcade_glue_pkg::sw_t       sw,
	output logic                       blitter_sc2,
	output logic                       sinistar,
	output logic                       speech_en,
	output logic                       sin_fire_n,
	output logic                       sin_bomb_n,
	output logic [1:0]                 orientation
);
	import arcade_glue_pkg::*;

	logic up1, down1, left1, right1;
	logic fire1a, fire1b, fire1c, fire1d, fire1e;
	logic up2, down2, left2, right2;
	logic fire2a, fire2b, fire2c, fire2d, fire2e;
	logic start1, start2, coin_any;
	logic sin_x, sin_y;
	joy_t twin_stick;

	// Fire F is not wired on any of these cabinets
	assign {fire1e, fire1d, fire1c, fire1b, fire1a, up1, down1, left1, right1} = player1[8:0];
	assign {fire2e, fire2d, fire2c, fire2b, fire2a, up2, down2, left2, right2} = player2[8:0];

	assign start1   = controls[0];
	assign start2   = controls[1];
	assign coin_any = controls[4] | controls[5]; // Coin 1 or coin 2

	// Second stick fires in Robotron and Splat, MAME style
	assign twin_stick = ~{fire1d | right2, fire1c | left2, fire1b | down2, fire1a | up2,
		right1, left1, down1, up1};

	assign sin_fire_n = ~fire1a & ~fire2a;
	assign sin_bomb_n = ~fire1b & ~fire2b;

	always_comb
	begin
		orientation = ORIENT_LANDSCAPE;
		sw          = {6'h00, advance, autoup};
		ja          = 8'hFF;
		jb          = 8'hFF;
		btn         = 4'hF;
		blitter_sc2 = 1'b0;
		sinistar    = 1'b0;
		speech_en   = 1'b0;

		case (core_mod)
			CORE_ROBOTRON:
			begin
				btn = {start1, start2, coin_any, game_reset};
				ja  = twin_stick;
				jb  = twin_stick;
			end
			CORE_JOUST:
			begin
				btn = {start2, start1, coin_any, game_reset};
				ja  = ~{5'b00000, fire1a, right1, left1}; // Flap on fire A
				jb  = ~{5'b00000, fire2a, right2, left2};
			end
			CORE_SPLAT:
			begin
				blitter_sc2 = 1'b1; // Newer blitter revision
				btn         = {start1, start2, coin_any, game_reset};
				ja          = twin_stick;
				jb          = twin_stick;
			end
			CORE_BUBBLES:
			begin
				btn = {start2, start1, coin_any, game_reset};
				ja  = ~{4'b0000, right1, left1, down1, up1};
				jb  = ~{4'b0000, right2, left2, down2, up2};
			end
			CORE_STARGATE:
			begin
				btn = {start2, start1, coin_any, game_reset};
				// Either horizontal direction means reverse
				ja  = ~{fire1e, up1, down1, left1 | right1, fire1d, fire1c, fire1b, fire1a};
				jb  = ~{fire2e, up2, down2, left2 | right2, fire2d, fire2c, fire2b, fire2a};
			end
			CORE_ALIENAR:
			begin
				btn = {start1, start2, coin_any, game_reset};
				ja  = ~{2'b00, fire1b, fire1a, right1, left1, down1, up1};
				jb  = ~{2'b00, fire2b, fire2a, right2, left2, down2, up2};
			end
			CORE_SINISTAR:
			begin
				sinistar    = 1'b1;
				speech_en   = 1'b1;
				orientation = ORIENT_PORTRAIT;
				btn         = {start2, start1, coin_any, game_reset};
				// 49-way stick emulation: sign latch plus any-movement flag
				ja = {sin_x, 2'b00, right1 | left1 | right2 | left2,
					sin_y, 2'b00, up1 | down1 | up2 | down2};
				jb = ja;
			end
			CORE_PLAYBALL:
			begin
				speech_en   = 1'b1;
				orientation = ORIENT_PORTRAIT;
				btn         = {2'b00, coin_any, game_reset};
				ja          = ~{4'b0000, start2, right1, left1, start1};
				jb          = ja;
			end
			CORE_LOTTO:
			begin
				btn = {start1, start2, coin_any, game_reset};
				ja  = ~{2'b00, fire1b, fire1a, right1, left1, down1, up1};
				jb  = ja;
			end
			default: ;
		endcase
	end

	// Sinistar direction latches, right and up win
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			sin_x <= 1'b0;
			sin_y <= 1'b0;
		end
		else
		begin
			if (right1 | right2)
				sin_x <= 1'b0;
			else if (left1 | left2)
				sin_x <= 1'b1;

			if (up1 | up2)
				sin_y <= 1'b0;
			else if (down1 | down2)
				sin_y <= 1'b1;
		end
	end

endmodule

//--- design/advance_pulse.sv
/*
 * Advance pulse stretcher
 * Turns the menu advance toggle into a long service switch pulse
 */
`timescale 1ns/100ps

module advance_pulse (
	input  logic clk_sys,
	input  logic rst,
	input  logic adv,
	output logic advance
);
	import arcade_glue_pkg::*;

	logic        adv_d;
	logic [19:0] hold_cnt;

	assign advance = (hold_cnt != '0);

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			adv_d    <= 1'b0;
			hold_cnt <= '0;
		end
		else
		begin
			adv_d <= adv;
			if (adv & ~adv_d)
				hold_cnt <= ADV_HOLD; // Rising edge restarts the hold
			else if (advance)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

endmodule

//--- design/boot_reset.sv
/*
 * Boot reset
 * Keeps the game in reset until a ROM image has been downloaded
 */
`timescale 1ns/100ps

module boot_reset (
	input  logic clk_sys,
	input  logic rst,
	input  logic menu_reset,
	input  logic button_reset,
	input  logic downloading,
	output logic game_reset
);

	logic downloading_d;
	logic rom_loaded;

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			downloading_d <= 1'b0;
			rom_loaded    <= 1'b0;
			game_reset    <= 1'b1;
		end
		else
		begin
			downloading_d <= downloading;

			// End of a download means an image is present
			if (downloading_d & ~downloading)
				rom_loaded <= 1'b1;

			game_reset <= menu_reset | button_reset | downloading | ~rom_loaded;
		end
	end

endmodule

//--- rom_port/rom_port_mapper.sv
/*
 * ROM port mapper
 * Places download bytes into the SDRAM word layout with a request toggle
 * per write, and translates CPU memory addresses to SDRAM addresses
 */
`timescale 1ns/100ps

module rom_port_mapper (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         downloading,
	input  logic                         dl_wr,
	input  arcade_glue_pkg::dl_addr_t    dl_addr,
	input  logic [7:0]                   dl_data,
	input  arcade_glue_pkg::cpu_addr_t   mem_addr,
	input  logic                         rom_cs_n,
	output logic                         port_req,
	output arcade_glue_pkg::sdram_addr_t port_addr,
	output logic [15:0]                  port_data,
	output arcade_glue_pkg::sdram_addr_t cpu_sdram_addr
);
	import arcade_glue_pkg::*;

	logic        dl_wr_last;
	logic        dl_strobe;
	sdram_addr_t dl_sdram_addr;
	logic [16:0] cpu_map;

	assign dl_strobe = downloading & dl_wr & ~dl_wr_last;

	// CMOS page moves to its own area, everything else maps straight
	assign dl_sdram_addr = (dl_addr[24:CMOS_OFS_W] == CMOS_PAGE[24:CMOS_OFS_W]) ?
		CMOS_BASE + {13'd0, dl_addr[CMOS_OFS_W-1:0]} : dl_addr[22:0];

	// ROM 0xxx-8xxx direct, Dxxx-Fxxx folds to 9xxx-Bxxx; RAM in upper half
	assign cpu_map = ~rom_cs_n ?
		{1'b0, mem_addr[16], ~mem_addr[16] & mem_addr[15], mem_addr[14:1]} :
		{1'b1, mem_addr[16:1]};

	assign cpu_sdram_addr = downloading ? '1 : {6'd0, cpu_map}; // Parked during download

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			dl_wr_last <= 1'b0;
			port_req   <= 1'b0;
		end
		else
		begin
			dl_wr_last <= dl_wr;
			if (dl_strobe)
				port_req <= ~port_req; // Any change is a new write
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (dl_strobe)
		begin
			port_addr <= dl_sdram_addr;
			port_data <= {dl_data[7:4], dl_data[7:4], dl_data[3:0], dl_data[3:0]};
		end
	end

endmodule

//--- design/audio_dac.sv
/*
 * Audio DAC
 * Mixes game sound with optional speech and drives a first-order
 * sigma-delta modulator with a one-bit output
 */
`timescale 1ns/100ps

module audio_dac (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  arcade_glue_pkg::snd_t    snd,
	input  arcade_glue_pkg::speech_t speech,
	input  logic                    speech_en,
	output logic                    dac_out
);
	import arcade_glue_pkg::*;

	mix_t        mix;
	mix_t        acc;
	logic [17:0] acc_sum;

	// Sound byte doubled to 16 bits, headroom bit for the speech sum
	always_comb
	begin
		mix = {1'b0, snd, snd};
		if (speech_en)
			mix = mix + {1'b0, speech};
	end

	assign acc_sum = {1'b0, acc} + {1'b0, mix};

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			acc     <= '0;
			dac_out <= 1'b0;
		end
		else
		begin
			acc     <= acc_sum[16:0];
			dac_out <= acc_sum[17]; // Carry is the pulse density
		end
	end

endmodule

//--- design/arcade_glue_top.sv
/*
 * Arcade glue top level
 * Input mapping, advance pulse, boot reset, ROM port and audio DAC
 * between the platform services and the game SoC
 */
`timescale 1ns/100ps

module arcade_glue_top (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  arcade_glue_pkg::core_mod_t   core_mod,
	input  arcade_glue_pkg::status_t     status,
	input  logic                         button_reset,
	input  arcade_glue_pkg::player_t     player1,
	input  arcade_glue_pkg::player_t     player2,
	input  arcade_glue_pkg::ctrl_t       controls,
	input  logic                         downloading,
	input  logic                         dl_wr,
	input  arcade_glue_pkg::dl_addr_t    dl_addr,
	input  logic [7:0]                   dl_data,
	input  arcade_glue_pkg::cpu_addr_t   mem_addr,
	input  logic                         rom_cs_n,
	input  arcade_glue_pkg::snd_t        snd,
	input  arcade_glue_pkg::speech_t     speech,
	output arcade_glue_pkg::btn_t        btn,
	output arcade_glue_pkg::joy_t        ja,
	output arcade_glue_pkg::joy_t        jb,
	output arcade_glue_pkg::sw_t         sw,
	output logic                         blitter_sc2,
	output logic                         sinistar,
	output logic                         sin_fire_n,
	output logic                         sin_bomb_n,
	output logic [1:0]                   orientation,
	output logic                         game_reset,
	output logic                         port_req,
	output arcade_glue_pkg::sdram_addr_t port_addr,
	output logic [15:0]                  port_data,
	output arcade_glue_pkg::sdram_addr_t cpu_sdram_addr,
	output logic                         dac_out
);

	logic speech_en;
	logic advance;

	game_input_map u_game_input_map (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.core_mod    (core_mod),
		.player1     (player1),
		.player2     (player2),
		.controls    (controls),
		.advance     (advance),
		.autoup      (status[7]), // Lotto Fun memory protect
		.game_reset  (game_reset),
		.btn         (btn),
		.ja          (ja),
		.jb          (jb),
		.sw          (sw),
		.blitter_sc2 (blitter_sc2),
		.sinistar    (sinistar),
		.speech_en   (speech_en),
		.sin_fire_n  (sin_fire_n),
		.sin_bomb_n  (sin_bomb_n),
		.orientation (orientation)
	);

	advance_pulse u_advance_pulse (
		.clk_sys (clk_sys),
		.rst     (rst),
		.adv     (status[8]),
		.advance (advance)
	);

	boot_reset u_boot_reset (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.menu_reset   (status[0]),
		.button_reset (button_reset),
		.downloading  (downloading),
		.game_reset   (game_reset)
	);

	rom_port_mapper u_rom_port_mapper (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.downloading    (downloading),
		.dl_wr          (dl_wr),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data),
		.mem_addr       (mem_addr),
		.rom_cs_n       (rom_cs_n),
		.port_req       (port_req),
		.port_addr      (port_addr),
		.port_data      (port_data),
		.cpu_sdram_addr (cpu_sdram_addr)
	);

	audio_dac u_audio_dac (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.snd       (snd),
		.speech    (speech),
		.speech_en (speech_en),
		.dac_out   (dac_out)
	);

endmodule

//--- testbench/tb_model.svh
/*
 * Arcade glue reference model
 * Cabinet wiring per game, download and CPU address maps, sigma-delta step
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Directions as {right, left, down, up}
function automatic logic [3:0] dirs_rldu(input player_t p);
	return {p[0], p[1], p[2], p[3]};
endfunction

// One Sinistar latch, the clearing direction wins
function automatic logic model_latch(input logic cur, input logic clr, input logic set);
	if (clr)
		return 1'b0;
	if (set)
		return 1'b1;
	return cur;
endfunction

function automatic void model_map(
	input  core_mod_t  m,
	input  player_t    p1,
	input  player_t    p2,
	input  ctrl_t      c,
	input  logic       rst_bit,
	input  logic       sx,
	input  logic       sy,
	output btn_t       exp_btn,
	output joy_t       exp_ja,
	output joy_t       exp_jb,
	output logic [1:0] orient,
	output logic       blit
);
	joy_t ha;
	joy_t hb;
	logic s1;
	logic s2;
	logic coin;

	s1      = c[0];
	s2      = c[1];
	coin    = c[5] | c[4];
	exp_btn = {s1, s2, coin, rst_bit};
	ha      = '0; // Active high here, inverted below
	hb      = '0;
	orient  = ORIENT_LANDSCAPE;
	blit    = 1'b0;
	case (m)
		CORE_ROBOTRON, CORE_SPLAT:
		begin
			ha   = {p1[7:4] | dirs_rldu(p2), dirs_rldu(p1)}; // Second stick fires
			hb   = ha;
			blit = (m == CORE_SPLAT);
		end
		CORE_JOUST:
		begin
			exp_btn = {s2, s1, coin, rst_bit};
			ha      = {5'd0, p1[4], p1[0], p1[1]};
			hb      = {5'd0, p2[4], p2[0], p2[1]};
		end
		CORE_BUBBLES:
		begin
			exp_btn = {s2, s1, coin, rst_bit};
			ha      = {4'd0, dirs_rldu(p1)};
			hb      = {4'd0, dirs_rldu(p2)};
		end
		CORE_STARGATE:
		begin
			exp_btn = {s2, s1, coin, rst_bit};
			ha      = {p1[8], p1[3], p1[2], p1[1] | p1[0], p1[7:4]};
			hb      = {p2[8], p2[3], p2[2], p2[1] | p2[0], p2[7:4]};
		end
		CORE_ALIENAR, CORE_LOTTO:
		begin
			ha = {2'd0, p1[5:4], dirs_rldu(p1)};
			hb = (m == CORE_LOTTO) ? ha : {2'd0, p2[5:4], dirs_rldu(p2)};
		end
		CORE_SINISTAR:
		begin
			exp_btn = {s2, s1, coin, rst_bit};
			orient  = ORIENT_PORTRAIT;
		end
		CORE_PLAYBALL:
		begin
			exp_btn = {2'b00, coin, rst_bit};
			orient  = ORIENT_PORTRAIT;
			ha      = {4'd0, s2, p1[0], p1[1], s1};
			hb      = ha;
		end
		default:
			exp_btn = 4'hF;
	endcase
	exp_ja = ~ha;
	exp_jb = ~hb;
	if (m == CORE_SINISTAR)
	begin
		// Sign latch plus movement flag, not inverted
		exp_ja = {sx, 2'b00, |{p1[1:0], p2[1:0]}, sy, 2'b00, |{p1[3:2], p2[3:2]}};
		exp_jb = exp_ja;
	end
endfunction

function automatic sdram_addr_t model_dl_addr(input dl_addr_t a);
	if (a >= CMOS_PAGE && a < CMOS_PAGE + 25'h400)
		return CMOS_BASE + sdram_addr_t'(a - CMOS_PAGE);
	return a[22:0];
endfunction

function automatic sdram_addr_t model_cpu_addr(input cpu_addr_t m, input logic cs_n,
	input logic dl);
	sdram_addr_t w;

	w = {7'd0, m[16:1]};
	if (dl)
		return '1;
	if (cs_n)
		w[16] = 1'b1; // RAM in the upper half
	else if (m[16])
		w[14] = 1'b0; // Upper ROM folds down
	return w;
endfunction

// Returns {carry, next accumulator}
function automatic logic [17:0] model_dac_step(input mix_t acc, input snd_t s,
	input speech_t sp, input logic en);
	return acc + s * 18'd257 + (en ? sp : 16'd0);
endfunction

`endif

//--- testbench/tb_arcade_glue.sv
/*
 * Arcade glue testbench
 * Random stimulus against a reference model for input mapping, boot
 * reset, download port, CPU address map, audio DAC and advance pulse
 */
`timescale 1ns/100ps

module tb_arcade_glue;
	import arcade_glue_pkg::*;
	`include "tb_model.svh"

	// One full advance pulse plus the shorter tests
	localparam int TIMEOUT_CYCLES = int'(ADV_HOLD) + 20000;
	localparam int RESTART_AT     = 1000;

	logic clk_sys, rst, button_reset, downloading, dl_wr, rom_cs_n;
	core_mod_t core_mod;
	status_t status;
	player_t player1, player2;
	ctrl_t controls;
	dl_addr_t dl_addr;
	logic [7:0] dl_data;
	cpu_addr_t mem_addr;
	snd_t snd;
	speech_t speech;
	btn_t btn;
	joy_t ja, jb;
	sw_t sw;
	logic blitter_sc2, sinistar, sin_fire_n, sin_bomb_n, game_reset, port_req, dac_out;
	logic [1:0] orientation;
	sdram_addr_t port_addr, cpu_sdram_addr;
	logic [15:0] port_data;

	int cycles = 0;
	int hold;
	int count;
	logic sx_m, sy_m, req_prev, exp_blit, exp_dac;
	btn_t exp_btn;
	joy_t exp_ja, exp_jb;
	logic [1:0] exp_or;
	mix_t acc_m;
	logic [17:0] dac_next;

	arcade_glue_top u_arcade_glue_top (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	always @(posedge clk_sys)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", cycles);
			stop_on_failure();
		end
	end

	task automatic check_joy(input joy_t got, input joy_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_btn(input btn_t got, input btn_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_sw(input sw_t got, input sw_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(input sdram_addr_t got, input sdram_addr_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_data(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	// New inputs go in 1 ns after the edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	initial
	begin
		void'($urandom(32'h5247_b6b7));
		rst          = 1'b1;
		core_mod     = '0;
		status       = '0;
		button_reset = 1'b0;
		player1      = '0;
		player2      = '0;
		controls     = '0;
		downloading  = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		mem_addr     = '0;
		rom_cs_n     = 1'b1;
		snd          = '0;
		speech       = '0;
		repeat (3) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		// Input mapping before any ROM is loaded
		sx_m = 1'b0;
		sy_m = 1'b0;
		for (int i = 0; i < 2000; i++)
		begin
			core_mod  = core_mod_t'($urandom_range(0, 9));
			player1   = player_t'($urandom);
			player2   = player_t'($urandom);
			controls  = ctrl_t'($urandom);
			status[7] = 1'($urandom);
			@(negedge clk_sys);
			model_map(core_mod, player1, player2, controls, 1'b1, sx_m, sy_m,
				exp_btn, exp_ja, exp_jb, exp_or, exp_blit);
			check_btn(btn, exp_btn, "btn");
			check_joy(ja, exp_ja, "ja");
			check_joy(jb, exp_jb, "jb");
			check_sw(sw, {6'h00, 1'b0, status[7]}, "sw");
			check_bit(orientation[1], exp_or[1], "orientation bit 1");
			check_bit(orientation[0], exp_or[0], "orientation bit 0");
			check_bit(blitter_sc2, exp_blit, "blitter_sc2");
			check_bit(sinistar, core_mod == CORE_SINISTAR, "sinistar");
			check_bit(sin_fire_n, ~(player1[4] | player2[4]), "sin_fire_n");
			check_bit(sin_bomb_n, ~(player1[5] | player2[5]), "sin_bomb_n");
			check_bit(game_reset, 1'b1, "game_reset before download");
			// Latches follow at the coming edge
			sx_m = model_latch(sx_m, player1[0] | player2[0], player1[1] | player2[1]);
			sy_m = model_latch(sy_m, player1[3] | player2[3], player1[2] | player2[2]);
			step();
		end

		// Download writes with the CPU address parked
		downloading = 1'b1;
		req_prev    = 1'b0;
		for (int w = 0; w < 300; w++)
		begin
			case ($urandom_range(0, 3))
				0: dl_addr = CMOS_PAGE + dl_addr_t'($urandom_range(0, 1023));
				1: dl_addr = dl_addr_t'($urandom_range(0, 32'h1FFFF));
				default: dl_addr = dl_addr_t'($urandom);
			endcase
			dl_data  = 8'($urandom);
			dl_wr    = 1'b1;
			mem_addr = cpu_addr_t'($urandom);
			rom_cs_n = 1'($urandom);
			@(negedge clk_sys);
			check_addr(cpu_sdram_addr, model_cpu_addr(mem_addr, rom_cs_n, downloading),
				"cpu_sdram_addr while downloading");
			hold = $urandom_range(1, 3);
			for (int h = 0; h < hold; h++)
			begin
				step();
				if (h == 0)
				begin
					req_prev = ~req_prev; // One flip per rising dl_wr
					check_addr(port_addr, model_dl_addr(dl_addr), "port_addr");
					check_data(port_data,
						16'(dl_data[7:4]) * 16'h1100 + 16'(dl_data[3:0]) * 16'h0011,
						"port_data");
				end
				check_bit(port_req, req_prev, "port_req while dl_wr high");
			end
			dl_wr = 1'b0;
			repeat ($urandom_range(1, 2))
			begin
				step();
				check_bit(port_req, req_prev, "port_req while dl_wr low");
			end
		end

		// Reset release two edges after the download ends
		downloading = 1'b0;
		step();
		check_bit(game_reset, 1'b1, "game_reset one edge after download");
		step();
		check_bit(game_reset, 1'b0, "game_reset two edges after download");

		for (int i = 0; i < 500; i++)
		begin
			mem_addr = cpu_addr_t'($urandom);
			rom_cs_n = 1'($urandom);
			@(negedge clk_sys);
			check_addr(cpu_sdram_addr, model_cpu_addr(mem_addr, rom_cs_n, downloading),
				"cpu_sdram_addr");
			check_bit(game_reset, 1'b0, "game_reset with ROM loaded");
			model_map(core_mod, player1, player2, controls, 1'b0, sx_m, sy_m,
				exp_btn, exp_ja, exp_jb, exp_or, exp_blit);
			check_btn(btn, exp_btn, "btn with ROM loaded");
			step();
		end

		status[0] = 1'b1;
		step();
		check_bit(game_reset, 1'b1, "game_reset on menu reset");
		status[0] = 1'b0;
		step();
		check_bit(game_reset, 1'b0, "game_reset after menu reset");
		button_reset = 1'b1;
		step();
		check_bit(game_reset, 1'b1, "game_reset on reset button");
		button_reset = 1'b0;
		step();
		check_bit(game_reset, 1'b0, "game_reset after reset button");

		// Audio from an empty accumulator
		acc_m   = '0;
		exp_dac = 1'b0;
		for (int i = 0; i < 3000; i++)
		begin
			snd      = snd_t'($urandom);
			speech   = speech_t'($urandom);
			core_mod = core_mod_t'($urandom_range(0, 9));
			@(negedge clk_sys);
			check_bit(dac_out, exp_dac, "dac_out");
			dac_next = model_dac_step(acc_m, snd, speech,
				core_mod == CORE_SINISTAR || core_mod == CORE_PLAYBALL);
			acc_m   = dac_next[16:0];
			exp_dac = dac_next[17];
			step();
		end
		snd    = '0;
		speech = '0;

		// Advance pulse restarted part way through
		check_bit(sw[1], 1'b0, "advance before toggle");
		status[8] = 1'b1;
		step();
		for (int i = 0; i < RESTART_AT; i++)
		begin
			check_bit(sw[1], 1'b1, "advance during pulse");
			step();
		end
		status[8] = 1'b0;
		step();
		status[8] = 1'b1;
		step();
		count = 0;
		while (sw[1])
		begin
			count++;
			step();
		end
		check_count(count, int'(ADV_HOLD), "advance length after restart");

		$display("All checks passed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+testbench
common/arcade_glue_pkg.sv
input_map/game_input_map.sv
design/advance_pulse.sv
design/boot_reset.sv
rom_port/rom_port_mapper.sv
design/audio_dac.sv
design/arcade_glue_top.sv
testbench/tb_arcade_glue.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the arcade glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_arcade_glue -f sources.f \
	-o tb_arcade_glue > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_arcade_glue > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
